//--- tb.f
logic/safe_pkg.sv
logic/csr_bus_if.sv
logic/majority_voter.sv
logic/lockstep_comparator.sv
logic/redundancy_mux.sv
logic/safe_csr.sv
logic/safe_bus_wrapper.sv
sim/tb_safe_bus_wrapper.sv

//--- sim/tb_safe_bus_wrapper.sv
/*
 * Testbench for the redundancy bus wrapper with clock and reset,
 * LFSR stimulus, memory responder model, register bus accesses
 * and assertion checks
 */
`timescale 1ns/1ps

module tb_safe_bus_wrapper;
    import safe_pkg::*;

    localparam int WAIT_LIMIT = 20;
    // Memory read data is the port address XOR its key
    localparam logic [NHARTS-1:0][31:0] PORT_KEY = {32'hc0de_0222, 32'hc0de_0111, 32'hc0de_0000};

    logic clk_i;
    logic reset_i;
    logic [NHARTS-1:0]             hart_instr_req_i;
    logic [NHARTS-1:0][ADDR_W-1:0] hart_instr_addr_i;
    logic [NHARTS-1:0]             hart_instr_gnt_o;
    logic [NHARTS-1:0]             hart_instr_rvalid_o;
    logic [NHARTS-1:0][DATA_W-1:0] hart_instr_rdata_o;
    logic [NHARTS-1:0]             mem_instr_req_o;
    logic [NHARTS-1:0][ADDR_W-1:0] mem_instr_addr_o;
    logic [NHARTS-1:0]             mem_instr_gnt_i;
    logic [NHARTS-1:0]             mem_instr_rvalid_i;
    logic [NHARTS-1:0][DATA_W-1:0] mem_instr_rdata_i;
    logic [NHARTS-1:0]             hart_data_req_i;
    logic [NHARTS-1:0]             hart_data_we_i;
    logic [NHARTS-1:0][BE_W-1:0]   hart_data_be_i;
    logic [NHARTS-1:0][ADDR_W-1:0] hart_data_addr_i;
    logic [NHARTS-1:0][DATA_W-1:0] hart_data_wdata_i;
    logic [NHARTS-1:0]             hart_data_gnt_o;
    logic [NHARTS-1:0]             hart_data_rvalid_o;
    logic [NHARTS-1:0][DATA_W-1:0] hart_data_rdata_o;
    logic [NHARTS-1:0]             mem_data_req_o;
    logic [NHARTS-1:0]             mem_data_we_o;
    logic [NHARTS-1:0][BE_W-1:0]   mem_data_be_o;
    logic [NHARTS-1:0][ADDR_W-1:0] mem_data_addr_o;
    logic [NHARTS-1:0][DATA_W-1:0] mem_data_wdata_o;
    logic [NHARTS-1:0]             mem_data_gnt_i;
    logic [NHARTS-1:0]             mem_data_rvalid_i;
    logic [NHARTS-1:0][DATA_W-1:0] mem_data_rdata_i;
    logic              csr_req_i;
    logic              csr_we_i;
    logic [ADDR_W-1:0] csr_addr_i;
    logic [DATA_W-1:0] csr_wdata_i;
    logic              csr_gnt_o;
    logic              csr_rvalid_o;
    logic [DATA_W-1:0] csr_rdata_o;

    // Hart payloads and the common payload before corruption
    instr_req_t [NHARTS-1:0] h_ireq;
    data_req_t  [NHARTS-1:0] h_dreq;
    instr_req_t              good_i;
    data_req_t               good_d;
    logic [31:0]             lfsr_state;

    // Memory model state
    logic [NHARTS-1:0]             ivalid_q = '0;
    logic [NHARTS-1:0]             dvalid_q = '0;
    logic [NHARTS-1:0][ADDR_W-1:0] iaddr_q = '0;
    logic [NHARTS-1:0][ADDR_W-1:0] daddr_q = '0;

    safe_bus_wrapper u_safe_bus_wrapper (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Memory grants at once and answers one cycle later
    always @(posedge clk_i) begin
        ivalid_q <= mem_instr_req_o & mem_instr_gnt_i;
        dvalid_q <= mem_data_req_o & mem_data_gnt_i;
        iaddr_q  <= mem_instr_addr_o;
        daddr_q  <= mem_data_addr_o;
    end

    always @(negedge clk_i) begin
        mem_instr_rvalid_i = ivalid_q;
        mem_data_rvalid_i  = dvalid_q;
        for (int p = 0; p < NHARTS; p++) begin
            mem_instr_rdata_i[p] = iaddr_q[p] ^ PORT_KEY[p];
            mem_data_rdata_i[p]  = daddr_q[p] ^ PORT_KEY[p];
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int first_of(input logic [1:0] pair);
        return (pair == PAIR_12) ? 1 : 0;
    endfunction

    function automatic int second_of(input logic [1:0] pair);
        return (pair == PAIR_12 || pair == PAIR_02) ? 2 : 1;
    endfunction

    function automatic int spare_of(input logic [1:0] pair);
        if (pair == PAIR_12) begin
            return 0;
        end
        return (pair == PAIR_02) ? 1 : 2;
    endfunction

    // Port whose response a hart receives
    function automatic int rsp_port(input logic [1:0] mode, input logic [1:0] pair, input int h);
        if (mode == MODE_TRIPLE) begin
            return 0;
        end
        if (mode == MODE_DUAL) begin
            return (h == spare_of(pair)) ? 1 : 0;
        end
        return h;
    endfunction

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [69:0] got,
                               input logic [69:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic apply_harts();
        for (int h = 0; h < NHARTS; h++) begin
            {hart_instr_req_i[h], hart_instr_addr_i[h]} = h_ireq[h];
            {hart_data_req_i[h], hart_data_we_i[h], hart_data_be_i[h],
             hart_data_addr_i[h], hart_data_wdata_i[h]} = h_dreq[h];
        end
    endtask

    task automatic random_harts(input bit same);
        instr_req_t ir;
        data_req_t  dr;
        for (int h = 0; h < NHARTS; h++) begin
            if (!same || h == 0) begin
                ir.req   = 1'b1;
                ir.addr  = random_bits(32);
                dr.req   = 1'b1;
                dr.we    = random_bits(1) != 0;
                dr.be    = 4'(random_bits(4));
                dr.addr  = random_bits(32);
                dr.wdata = random_bits(32);
            end
            h_ireq[h] = ir;
            h_dreq[h] = dr;
        end
        good_i = h_ireq[0];
        good_d = h_dreq[0];
    endtask

    task automatic flip_data_addr(input int h);
        int b;
        b = int'(random_bits(5));
        h_dreq[h].addr[b] = ~h_dreq[h].addr[b];
    endtask

    // One request cycle and one idle cycle that carries the responses
    task automatic run_transaction(input logic [1:0] mode, input logic [1:0] pair);
        instr_req_t [NHARTS-1:0] exp_i;
        data_req_t  [NHARTS-1:0] exp_d;
        int p;
        int n;
        exp_i = '0;
        exp_d = '0;
        if (mode == MODE_TRIPLE) begin
            exp_i[0] = good_i;
            exp_d[0] = good_d;
        end else if (mode == MODE_DUAL) begin
            exp_i[0] = h_ireq[first_of(pair)];
            exp_d[0] = h_dreq[first_of(pair)];
            exp_i[1] = h_ireq[spare_of(pair)];
            exp_d[1] = h_dreq[spare_of(pair)];
        end else begin
            exp_i = h_ireq;
            exp_d = h_dreq;
        end
        @(negedge clk_i);
        apply_harts();
        #2;
        for (int q = 0; q < NHARTS; q++) begin
            check_value($sformatf("mem_instr port %0d", q),
                        {mem_instr_req_o[q], mem_instr_addr_o[q]}, exp_i[q]);
            check_value($sformatf("mem_data port %0d", q),
                        {mem_data_req_o[q], mem_data_we_o[q], mem_data_be_o[q],
                         mem_data_addr_o[q], mem_data_wdata_o[q]}, exp_d[q]);
        end
        check_value("hart_instr_gnt_o", hart_instr_gnt_o, 3'b111);
        check_value("hart_data_gnt_o", hart_data_gnt_o, 3'b111);
        @(negedge clk_i);
        h_ireq = '0;
        h_dreq = '0;
        apply_harts();
        #2;
        n = 0;
        while (hart_instr_rvalid_o !== 3'b111 || hart_data_rvalid_o !== 3'b111) begin
            if (n >= WAIT_LIMIT) begin
                $display("ERROR: hart read responses never arrived, time %0t", $time);
                stop_with_failure();
            end
            @(negedge clk_i);
            #2;
            n++;
        end
        for (int h = 0; h < NHARTS; h++) begin
            p = rsp_port(mode, pair, h);
            check_value($sformatf("hart_instr_rdata_o[%0d]", h), hart_instr_rdata_o[h],
                        exp_i[p].addr ^ PORT_KEY[p]);
            check_value($sformatf("hart_data_rdata_o[%0d]", h), hart_data_rdata_o[h],
                        exp_d[p].addr ^ PORT_KEY[p]);
        end
    endtask

    task automatic csr_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        @(negedge clk_i);
        csr_req_i   = 1'b1;
        csr_we_i    = we;
        csr_addr_i  = addr;
        csr_wdata_i = wdata;
        #2;
        n = 0;
        while (!csr_gnt_o) begin
            if (n >= WAIT_LIMIT) begin
                $display("ERROR: register bus grant never arrived, time %0t", $time);
                stop_with_failure();
            end
            @(negedge clk_i);
            #2;
            n++;
        end
        check_value("csr_gnt_o delay", n, 0);
        @(negedge clk_i);
        csr_req_i = 1'b0;
        csr_we_i  = 1'b0;
        #2;
        n = 0;
        while (!csr_rvalid_o) begin
            if (n >= WAIT_LIMIT) begin
                $display("ERROR: register bus read valid never arrived, time %0t", $time);
                stop_with_failure();
            end
            @(negedge clk_i);
            #2;
            n++;
        end
        check_value("csr_rvalid_o delay", n, 0);
        rdata = csr_rdata_o;
    endtask

    task automatic csr_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        csr_access(1'b1, addr, data, unused);
    endtask

    task automatic csr_expect(input string name, input logic [31:0] addr,
                              input logic [31:0] mask, input logic [31:0] exp);
        logic [31:0] rd;
        csr_access(1'b0, addr, 32'd0, rd);
        check_value(name, rd & mask, exp & mask);
    endtask

    initial begin : main
        int bad;
        int count_exp;
        logic [2:0] pmask;
        lfsr_state      = 32'h42640603;
        reset_i         = 1'b1;
        h_ireq          = '0;
        h_dreq          = '0;
        apply_harts();
        mem_instr_gnt_i = '1;
        mem_data_gnt_i  = '1;
        mem_instr_rvalid_i = '0;
        mem_data_rvalid_i  = '0;
        mem_instr_rdata_i  = '0;
        mem_data_rdata_i   = '0;
        csr_req_i   = 1'b0;
        csr_we_i    = 1'b0;
        csr_addr_i  = '0;
        csr_wdata_i = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        #2;
        check_value("mem_instr_req_o", mem_instr_req_o, 3'b000);
        check_value("mem_data_req_o", mem_data_req_o, 3'b000);
        check_value("csr_rvalid_o", csr_rvalid_o, 1'b0);

        // Split after reset
        csr_expect("CTRL", CSR_CTRL, 32'hf, 32'h0);
        repeat (2) begin
            random_harts(1'b0);
            run_transaction(MODE_SPLIT, PAIR_01);
        end
        csr_expect("STATUS", CSR_STATUS, 32'h1f, 32'h0);
        csr_expect("COUNT", CSR_COUNT, 32'hffff_ffff, 32'h0);

        // Triple with agreeing harts and then one corrupted hart
        csr_write(CSR_CTRL, {28'd0, PAIR_01, MODE_TRIPLE});
        csr_expect("CTRL", CSR_CTRL, 32'hf, {28'd0, PAIR_01, MODE_TRIPLE});
        random_harts(1'b1);
        run_transaction(MODE_TRIPLE, PAIR_01);
        csr_expect("STATUS", CSR_STATUS, 32'h3, 32'h0);
        csr_expect("COUNT", CSR_COUNT, 32'hffff_ffff, 32'h0);
        bad = int'(random_bits(2)) % 3;
        random_harts(1'b1);
        flip_data_addr(bad);
        run_transaction(MODE_TRIPLE, PAIR_01);
        csr_expect("STATUS", CSR_STATUS, 32'h1f, (32'd1 << (bad + 2)) | 32'h1);
        count_exp = 1;
        csr_expect("COUNT", CSR_COUNT, 32'hffff_ffff, count_exp);
        csr_write(CSR_STATUS, 32'h3);
        csr_expect("STATUS", CSR_STATUS, 32'h3, 32'h0);

        // Dual for each pair with a pair mismatch and a spare-only mismatch
        for (int pr = 0; pr < 3; pr++) begin
            pmask = 3'b111 & ~(3'b001 << spare_of(2'(pr)));
            csr_write(CSR_CTRL, {28'd0, 2'(pr), MODE_DUAL});
            csr_expect("CTRL", CSR_CTRL, 32'hf, {28'd0, 2'(pr), MODE_DUAL});
            random_harts(1'b1);
            run_transaction(MODE_DUAL, 2'(pr));
            csr_expect("STATUS", CSR_STATUS, 32'h3, 32'h0);
            random_harts(1'b1);
            flip_data_addr(second_of(2'(pr)));
            run_transaction(MODE_DUAL, 2'(pr));
            count_exp++;
            csr_expect("STATUS", CSR_STATUS, 32'h1f, {27'd0, pmask, 2'b10});
            csr_expect("COUNT", CSR_COUNT, 32'hffff_ffff, count_exp);
            csr_write(CSR_STATUS, 32'h3);
            random_harts(1'b1);
            flip_data_addr(spare_of(2'(pr)));
            run_transaction(MODE_DUAL, 2'(pr));
            csr_expect("STATUS", CSR_STATUS, 32'h3, 32'h0);
            csr_expect("COUNT", CSR_COUNT, 32'hffff_ffff, count_exp);
        end

        // Any write clears the counter
        csr_write(CSR_COUNT, 32'h0000_ffff);
        csr_expect("COUNT", CSR_COUNT, 32'hffff_ffff, 32'h0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- logic/safe_bus_wrapper.sv
/*
 * Top level of the redundancy bus wrapper: instruction and data channel
 * muxes plus the control/status register block
 */
`timescale 1ns/1ps

module safe_bus_wrapper #(
    parameter safe_pkg::mode_e RESET_MODE = safe_pkg::MODE_SPLIT
) (
    input  logic clk_i,
    input  logic reset_i,

    // Hart instruction buses
    input  logic [safe_pkg::NHARTS-1:0]                      hart_instr_req_i,
    input  logic [safe_pkg::NHARTS-1:0][safe_pkg::ADDR_W-1:0] hart_instr_addr_i,
    output logic [safe_pkg::NHARTS-1:0]                      hart_instr_gnt_o,
    output logic [safe_pkg::NHARTS-1:0]                      hart_instr_rvalid_o,
    output logic [safe_pkg::NHARTS-1:0][safe_pkg::DATA_W-1:0] hart_instr_rdata_o,

    // Memory instruction ports
    output logic [safe_pkg::NHARTS-1:0]                      mem_instr_req_o,
    output logic [safe_pkg::NHARTS-1:0][safe_pkg::ADDR_W-1:0] mem_instr_addr_o,
    input  logic [safe_pkg::NHARTS-1:0]                      mem_instr_gnt_i,
    input  logic [safe_pkg::NHARTS-1:0]                      mem_instr_rvalid_i,
    input  logic [safe_pkg::NHARTS-1:0][safe_pkg::DATA_W-1:0] mem_instr_rdata_i,

    // Hart data buses
    input  logic [safe_pkg::NHARTS-1:0]                      hart_data_req_i,
    input  logic [safe_pkg::NHARTS-1:0]                      hart_data_we_i,
    input  logic [safe_pkg::NHARTS-1:0][safe_pkg::BE_W-1:0]   hart_data_be_i,
    input  logic [safe_pkg::NHARTS-1:0][safe_pkg::ADDR_W-1:0] hart_data_addr_i,
    input  logic [safe_pkg::NHARTS-1:0][safe_pkg::DATA_W-1:0] hart_data_wdata_i,
    output logic [safe_pkg::NHARTS-1:0]                      hart_data_gnt_o,
    output logic [safe_pkg::NHARTS-1:0]                      hart_data_rvalid_o,
    output logic [safe_pkg::NHARTS-1:0][safe_pkg::DATA_W-1:0] hart_data_rdata_o,

    // Memory data ports
    output logic [safe_pkg::NHARTS-1:0]                      mem_data_req_o,
    output logic [safe_pkg::NHARTS-1:0]                      mem_data_we_o,
    output logic [safe_pkg::NHARTS-1:0][safe_pkg::BE_W-1:0]   mem_data_be_o,
    output logic [safe_pkg::NHARTS-1:0][safe_pkg::ADDR_W-1:0] mem_data_addr_o,
    output logic [safe_pkg::NHARTS-1:0][safe_pkg::DATA_W-1:0] mem_data_wdata_o,
    input  logic [safe_pkg::NHARTS-1:0]                      mem_data_gnt_i,
    input  logic [safe_pkg::NHARTS-1:0]                      mem_data_rvalid_i,
    input  logic [safe_pkg::NHARTS-1:0][safe_pkg::DATA_W-1:0] mem_data_rdata_i,

    // Register bus
    input  logic                        csr_req_i,
    input  logic                        csr_we_i,
    input  logic [safe_pkg::ADDR_W-1:0] csr_addr_i,
    input  logic [safe_pkg::DATA_W-1:0] csr_wdata_i,
    output logic                        csr_gnt_o,
    output logic                        csr_rvalid_o,
    output logic [safe_pkg::DATA_W-1:0] csr_rdata_o
);
    import safe_pkg::*;

    instr_req_t [NHARTS-1:0] hart_instr_req;
    instr_req_t [NHARTS-1:0] mem_instr_req;
    bus_rsp_t   [NHARTS-1:0] hart_instr_rsp;
    bus_rsp_t   [NHARTS-1:0] mem_instr_rsp;
    data_req_t  [NHARTS-1:0] hart_data_req;
    data_req_t  [NHARTS-1:0] mem_data_req;
    bus_rsp_t   [NHARTS-1:0] hart_data_rsp;
    bus_rsp_t   [NHARTS-1:0] mem_data_rsp;
    fault_t                  instr_fault;
    fault_t                  data_fault;
    mode_e                   mode;
    pair_e                   pair;

    csr_bus_if csr_bus ();

    // Pack plain ports into structs and back
    for (genvar i = 0; i < NHARTS; i++) begin : g_pack
        assign hart_instr_req[i] = '{req: hart_instr_req_i[i], addr: hart_instr_addr_i[i]};
        assign mem_instr_rsp[i]  = '{gnt:    mem_instr_gnt_i[i],
                                     rvalid: mem_instr_rvalid_i[i],
                                     rdata:  mem_instr_rdata_i[i]};
        assign hart_data_req[i]  = '{req:   hart_data_req_i[i],
                                     we:    hart_data_we_i[i],
                                     be:    hart_data_be_i[i],
                                     addr:  hart_data_addr_i[i],
                                     wdata: hart_data_wdata_i[i]};
        assign mem_data_rsp[i]   = '{gnt:    mem_data_gnt_i[i],
                                     rvalid: mem_data_rvalid_i[i],
                                     rdata:  mem_data_rdata_i[i]};

        assign mem_instr_req_o[i]     = mem_instr_req[i].req;
        assign mem_instr_addr_o[i]    = mem_instr_req[i].addr;
        assign hart_instr_gnt_o[i]    = hart_instr_rsp[i].gnt;
        assign hart_instr_rvalid_o[i] = hart_instr_rsp[i].rvalid;
        assign hart_instr_rdata_o[i]  = hart_instr_rsp[i].rdata;

        assign mem_data_req_o[i]      = mem_data_req[i].req;
        assign mem_data_we_o[i]       = mem_data_req[i].we;
        assign mem_data_be_o[i]       = mem_data_req[i].be;
        assign mem_data_addr_o[i]     = mem_data_req[i].addr;
        assign mem_data_wdata_o[i]    = mem_data_req[i].wdata;
        assign hart_data_gnt_o[i]     = hart_data_rsp[i].gnt;
        assign hart_data_rvalid_o[i]  = hart_data_rsp[i].rvalid;
        assign hart_data_rdata_o[i]   = hart_data_rsp[i].rdata;
    end

    assign csr_bus.req   = csr_req_i;
    assign csr_bus.we    = csr_we_i;
    assign csr_bus.addr  = csr_addr_i;
    assign csr_bus.wdata = csr_wdata_i;
    assign csr_gnt_o     = csr_bus.gnt;
    assign csr_rvalid_o  = csr_bus.rvalid;
    assign csr_rdata_o   = csr_bus.rdata;

    redundancy_mux #(
        .payload_t (instr_req_t)
    ) u_instr_mux (
        .hart_req_i (hart_instr_req),
        .mem_rsp_i  (mem_instr_rsp),
        .mode_i     (mode),
        .pair_i     (pair),
        .mem_req_o  (mem_instr_req),
        .hart_rsp_o (hart_instr_rsp),
        .fault_o    (instr_fault)
    );

    redundancy_mux #(
        .payload_t (data_req_t)
    ) u_data_mux (
        .hart_req_i (hart_data_req),
        .mem_rsp_i  (mem_data_rsp),
        .mode_i     (mode),
        .pair_i     (pair),
        .mem_req_o  (mem_data_req),
        .hart_rsp_o (hart_data_rsp),
        .fault_o    (data_fault)
    );

    safe_csr #(
        .RESET_MODE (RESET_MODE)
    ) u_csr (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .bus           (csr_bus.slave),
        .instr_fault_i (instr_fault),
        .data_fault_i  (data_fault),
        .mode_o        (mode),
        .pair_o        (pair)
    );

endmodule

//--- logic/safe_csr.sv
/*
 * Control/status registers: CTRL with mode and pair, sticky STATUS
 * with last fault mask, and a saturating fault cycle COUNT
 */
`timescale 1ns/1ps

module safe_csr #(
    parameter safe_pkg::mode_e RESET_MODE = safe_pkg::MODE_SPLIT
) (
    input  logic             clk_i,
    input  logic             reset_i,
    csr_bus_if.slave         bus,
    input  safe_pkg::fault_t instr_fault_i,
    input  safe_pkg::fault_t data_fault_i,
    output safe_pkg::mode_e  mode_o,
    output safe_pkg::pair_e  pair_o
);
    import safe_pkg::*;

    logic              vote_q;
    logic              cmp_q;
    logic [NHARTS-1:0] mask_q;
    logic [15:0]       count_q;
    logic [15:0]       count_base;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;
    logic              wr_ctrl;
    logic              wr_status;
    logic              wr_count;
    logic              any_vote;
    logic              any_cmp;

    // Accesses are always accepted in the request cycle
    assign bus.gnt    = bus.req;
    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

    assign wr_ctrl   = bus.req && bus.we && (bus.addr == CSR_CTRL);
    assign wr_status = bus.req && bus.we && (bus.addr == CSR_STATUS);
    assign wr_count  = bus.req && bus.we && (bus.addr == CSR_COUNT);

    assign any_vote = instr_fault_i.vote | data_fault_i.vote;
    assign any_cmp  = instr_fault_i.cmp | data_fault_i.cmp;

    // A write clears first, a fault in the same cycle still counts
    assign count_base = wr_count ? 16'd0 : count_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mode_o   <= RESET_MODE;
            pair_o   <= PAIR_01;
            vote_q   <= 1'b0;
            cmp_q    <= 1'b0;
            mask_q   <= '0;
            count_q  <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.req;
            if (wr_ctrl) begin
                mode_o <= mode_e'(bus.wdata[1:0]);
                pair_o <= pair_e'(bus.wdata[3:2]);
            end
            // New faults win over write-1-clear
            vote_q <= (vote_q & ~(wr_status & bus.wdata[0])) | any_vote;
            cmp_q  <= (cmp_q & ~(wr_status & bus.wdata[1])) | any_cmp;
            if (any_vote || any_cmp) begin
                mask_q <= instr_fault_i.mask | data_fault_i.mask;
            end
            if ((any_vote || any_cmp) && count_base != 16'hffff) begin
                count_q <= count_base + 16'd1;
            end else begin
                count_q <= count_base;
            end
        end
    end

    // Read data is sampled in the grant cycle
    always_ff @(posedge clk_i) begin
        if (bus.req) begin
            case (bus.addr)
                CSR_CTRL:   rdata_q <= {28'd0, pair_o, mode_o};
                CSR_STATUS: rdata_q <= {27'd0, mask_q, cmp_q, vote_q};
                CSR_COUNT:  rdata_q <= {16'd0, count_q};
                default:    rdata_q <= '0;
            endcase
        end
    end

endmodule

//--- logic/redundancy_mux.sv
/*
 * Per-channel routing between three harts and three memory ports for
 * split, triple and dual modes, plus mode-qualified fault reporting
 */
`timescale 1ns/1ps

module redundancy_mux #(
    parameter type payload_t = safe_pkg::instr_req_t
) (
    input  payload_t          [safe_pkg::NHARTS-1:0] hart_req_i,
    input  safe_pkg::bus_rsp_t [safe_pkg::NHARTS-1:0] mem_rsp_i,
    input  safe_pkg::mode_e                           mode_i,
    input  safe_pkg::pair_e                           pair_i,
    output payload_t          [safe_pkg::NHARTS-1:0] mem_req_o,
    output safe_pkg::bus_rsp_t [safe_pkg::NHARTS-1:0] hart_rsp_o,
    output safe_pkg::fault_t                          fault_o
);
    import safe_pkg::*;

    payload_t          voted;
    logic [NHARTS-1:0] mismatch;
    payload_t          primary;
    payload_t          spare;
    logic [1:0]        spare_idx;
    logic [NHARTS-1:0] pair_mask;
    logic              differ;
    logic [NHARTS-1:0] req_vec;
    logic              vote_active;
    logic              cmp_active;

    majority_voter #(
        .payload_t (payload_t)
    ) u_voter (
        .hart_req_i (hart_req_i),
        .voted_o    (voted),
        .mismatch_o (mismatch)
    );

    lockstep_comparator #(
        .payload_t (payload_t)
    ) u_comparator (
        .hart_req_i  (hart_req_i),
        .pair_i      (pair_i),
        .primary_o   (primary),
        .spare_o     (spare),
        .spare_idx_o (spare_idx),
        .pair_mask_o (pair_mask),
        .differ_o    (differ)
    );

    for (genvar i = 0; i < NHARTS; i++) begin : g_req_vec
        assign req_vec[i] = hart_req_i[i].req;
    end

    always_comb begin
        // Split is also the fallback for the unused mode encoding
        mem_req_o  = hart_req_i;
        hart_rsp_o = mem_rsp_i;
        case (mode_i)
            MODE_TRIPLE: begin
                mem_req_o    = '0;
                mem_req_o[0] = voted;
                for (int i = 0; i < NHARTS; i++) begin
                    hart_rsp_o[i] = mem_rsp_i[0];
                end
            end
            MODE_DUAL: begin
                mem_req_o[0] = primary;
                mem_req_o[1] = spare;
                mem_req_o[2] = '0;
                // Pair harts share port 0, spare runs alone on port 1
                for (int i = 0; i < NHARTS; i++) begin
                    if (spare_idx == 2'(i)) begin
                        hart_rsp_o[i] = mem_rsp_i[1];
                    end else begin
                        hart_rsp_o[i] = mem_rsp_i[0];
                    end
                end
            end
            default: begin
            end
        endcase
    end

    // Only count disagreement while a compared hart is actually requesting
    assign vote_active = |req_vec;
    assign cmp_active  = |(req_vec & pair_mask);

    always_comb begin
        fault_o = '0;
        if (mode_i == MODE_TRIPLE && vote_active && |mismatch) begin
            fault_o.vote = 1'b1;
            fault_o.mask = mismatch;
        end
        if (mode_i == MODE_DUAL && cmp_active && differ) begin
            fault_o.cmp  = 1'b1;
            fault_o.mask = pair_mask;
        end
    end

endmodule

//--- logic/lockstep_comparator.sv
/*
 * Lockstep pair selection and compare, returns the pair's first hart
 * as primary plus the spare hart's payload and index
 */
`timescale 1ns/1ps

module lockstep_comparator #(
    parameter type payload_t = safe_pkg::instr_req_t
) (
    input  payload_t [safe_pkg::NHARTS-1:0] hart_req_i,
    input  safe_pkg::pair_e                 pair_i,
    output payload_t                        primary_o,
    output payload_t                        spare_o,
    output logic [1:0]                      spare_idx_o,
    output logic [safe_pkg::NHARTS-1:0]     pair_mask_o,
    output logic                            differ_o
);
    import safe_pkg::*;

    logic [1:0] first_idx;
    logic [1:0] second_idx;
    payload_t   secondary;

    always_comb begin
        case (pair_i)
            PAIR_12: begin
                first_idx   = 2'd1;
                second_idx  = 2'd2;
                spare_idx_o = 2'd0;
            end
            PAIR_02: begin
                first_idx   = 2'd0;
                second_idx  = 2'd2;
                spare_idx_o = 2'd1;
            end
            // PAIR_01 and the unused encoding
            default: begin
                first_idx   = 2'd0;
                second_idx  = 2'd1;
                spare_idx_o = 2'd2;
            end
        endcase
    end

    assign primary_o   = hart_req_i[first_idx];
    assign secondary   = hart_req_i[second_idx];
    assign spare_o     = hart_req_i[spare_idx_o];
    assign pair_mask_o = (3'b001 << first_idx) | (3'b001 << second_idx);
    assign differ_o    = (primary_o != secondary);

endmodule

//--- logic/majority_voter.sv
/*
 * Bitwise 2-of-3 majority vote over one request payload, with a flag
 * per hart whose payload differs from the voted result
 */
`timescale 1ns/1ps

module majority_voter #(
    parameter type payload_t = safe_pkg::instr_req_t
) (
    input  payload_t [safe_pkg::NHARTS-1:0] hart_req_i,
    output payload_t                        voted_o,
    output logic [safe_pkg::NHARTS-1:0]     mismatch_o
);
    import safe_pkg::*;

    payload_t a;
    payload_t b;
    payload_t c;

    assign a = hart_req_i[0];
    assign b = hart_req_i[1];
    assign c = hart_req_i[2];

    // Each bit takes the value held by at least two harts
    assign voted_o = (a & b) | (a & c) | (b & c);

    // A single bad hart is the only one that disagrees with the vote
    for (genvar i = 0; i < NHARTS; i++) begin : g_mismatch
        assign mismatch_o[i] = (hart_req_i[i] != voted_o);
    end

endmodule

//--- logic/csr_bus_if.sv
/*
 * Register bus between the top level and the control/status block,
 * req/gnt handshake with a one-cycle rvalid response
 */
`timescale 1ns/1ps

interface csr_bus_if;
    import safe_pkg::*;

    // Request side
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // Response side
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;

    modport master (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport slave (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

//--- logic/safe_pkg.sv
/*
 * Shared widths, request and response structs, mode and pair encodings,
 * fault record and register offsets for the redundancy bus wrapper
 */
package safe_pkg;

    localparam int NHARTS = 3;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
    } instr_req_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [BE_W-1:0]   be;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } data_req_t;

    typedef struct packed {
        logic              gnt;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    // Encoding 3 falls back to split
    typedef enum logic [1:0] {
        MODE_SPLIT  = 2'd0,
        MODE_TRIPLE = 2'd1,
        MODE_DUAL   = 2'd2
    } mode_e;

    // Encoding 3 falls back to PAIR_01
    typedef enum logic [1:0] {
        PAIR_01 = 2'd0,
        PAIR_12 = 2'd1,
        PAIR_02 = 2'd2
    } pair_e;

    typedef struct packed {
        logic                   vote;
        logic                   cmp;
        logic [NHARTS-1:0]      mask;
    } fault_t;

    localparam logic [ADDR_W-1:0] CSR_CTRL   = 32'h0;
    localparam logic [ADDR_W-1:0] CSR_STATUS = 32'h4;
    localparam logic [ADDR_W-1:0] CSR_COUNT  = 32'h8;

endpackage
